/* src.f */
hw/tcdm_pkg.sv
hw/addr_dec_req.sv
hw/bank_arbiter.sv
hw/mem_bank.sv
hw/resp_router.sv
hw/log_interconnect_top.sv
tests/log_interconnect_chk.sv
tests/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_top -Mdir "$OBJ" -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_top_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tests/tb_top.sv */
/*
 * Directed testbench for the logarithmic interconnect
 * Four cores against four banks with grants and responses checked
 * against a reference memory and a per-bank round-robin pointer model
 */

`timescale 1ns/1ps

module tb_top;

    import tcdm_pkg::*;

    localparam int N_MASTER      = 4;
    localparam int N_BANK        = 4;
    localparam int CLK_PERIOD    = 100;
    // Sample point a quarter period before the rising edge
    localparam int SAMPLE_DLY    = 25;
    localparam int TIMEOUT       = 64;
    // Bank depth times bank count
    // Higher address bits alias onto these words
    localparam int MEM_WORDS     = 1024;
    localparam int N_RANDOM      = 200;
    localparam int CONFLICT_BANK = 2;

    logic                                clk;
    logic                                arst_n_i;
    logic [N_MASTER-1:0]                 req;
    core_req_t [N_MASTER-1:0]            core_req;
    logic [N_MASTER-1:0]                 gnt;
    logic [N_MASTER-1:0]                 r_valid;
    logic [N_MASTER-1:0][DATA_WIDTH-1:0] r_rdata;

    // Reference memory by word address
    logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    logic                  written [MEM_WORDS];
    // Expected priority pointer of each bank arbiter
    int                    rr_ptr  [N_BANK];
    int                    seed;

    log_interconnect_top #(
        .N_MASTER   (N_MASTER),
        .N_BANK     (N_BANK)
    ) log_interconnect_top_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (req),
        .core_req_i (core_req),
        .gnt_o      (gnt),
        .r_valid_o  (r_valid),
        .r_rdata_o  (r_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking and model helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            fail_stop($sformatf("CHECK FAILED at %0t ns: %s expected 0x%0h actual 0x%0h",
                                $time, name, exp, act));
    endtask

    // First pending core at or after the pointer
    function automatic int rr_winner(input logic [N_MASTER-1:0] pending, input int ptr);
        int idx;
        for (int i = 0; i < N_MASTER; i++)
        begin
            idx = (ptr + i) % N_MASTER;
            if (pending[idx])
                return idx;
        end
        return -1;
    endfunction

    // On a grant edge update the pointer and memory and return the word due back
    task automatic model_grant(input int core, input core_req_t r,
                               output logic [DATA_WIDTH-1:0] exp);
        int word;
        word = int'(r.addr) % MEM_WORDS;
        rr_ptr[int'(r.addr) % N_BANK] = (core + 1) % N_MASTER;
        if (r.wen)
        begin
            ref_mem[word] = r.wdata;
            written[word] = 1'b1;
        end
        exp = ref_mem[word];
    endtask

    // One access from one core held until granted and its response checked
    task automatic do_access(input int core, input logic wen,
                             input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] wdata);
        int                    cnt;
        logic [DATA_WIDTH-1:0] exp;
        @(negedge clk);
        req[core]            = 1'b1;
        core_req[core].wen   = wen;
        core_req[core].addr  = addr;
        core_req[core].wdata = wdata;
        cnt = 0;
        #(SAMPLE_DLY);
        while (!gnt[core])
        begin
            cnt++;
            if (cnt >= TIMEOUT)
                fail_stop($sformatf("Core %0d waited %0d cycles for a grant", core, cnt));
            @(negedge clk);
            #(SAMPLE_DLY);
        end
        // No response yet in the grant cycle
        check_val($sformatf("r_valid_o[%0d]", core), 0, r_valid[core]);
        model_grant(core, core_req[core], exp);
        @(negedge clk);
        req[core] = 1'b0;
        #(SAMPLE_DLY);
        check_val($sformatf("r_valid_o[%0d]", core), 1, r_valid[core]);
        check_val($sformatf("r_rdata_o[%0d]", core), exp, r_rdata[core]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    // Consecutive words hit the four banks in turn
    task automatic test_single_core();
        for (int i = 0; i < N_BANK; i++)
            do_access(1, 1'b1, ADDR_WIDTH'(16'h0040 + i), DATA_WIDTH'(32'hA5A5_0000 + i));
        for (int i = 0; i < N_BANK; i++)
            do_access(1, 1'b0, ADDR_WIDTH'(16'h0040 + i), '0);
    endtask

    // Core 0 writes and core 3 reads back
    task automatic test_cross_core();
        for (int i = 0; i < 8; i++)
            do_access(0, 1'b1, ADDR_WIDTH'(16'h0100 + 3 * i), DATA_WIDTH'(32'h0C0D_0000 + i));
        for (int i = 0; i < 8; i++)
            do_access(3, 1'b0, ADDR_WIDTH'(16'h0100 + 3 * i), '0);
    endtask

    // Every core on its own bank in the same cycle
    task automatic test_parallel();
        logic [DATA_WIDTH-1:0] exp [N_MASTER];
        for (int round = 0; round < 2; round++)
        begin
            @(negedge clk);
            for (int m = 0; m < N_MASTER; m++)
            begin
                req[m]            = 1'b1;
                core_req[m].wen   = (round == 0);
                // Core m aims at bank m + 1
                core_req[m].addr  = ADDR_WIDTH'(16'h0200 + 4 * m + (m + 1) % N_BANK);
                core_req[m].wdata = $random(seed);
            end
            #(SAMPLE_DLY);
            check_val("gnt_o", {N_MASTER{1'b1}}, gnt);
            for (int m = 0; m < N_MASTER; m++)
                model_grant(m, core_req[m], exp[m]);
            @(negedge clk);
            req = '0;
            #(SAMPLE_DLY);
            check_val("r_valid_o", {N_MASTER{1'b1}}, r_valid);
            for (int m = 0; m < N_MASTER; m++)
                check_val($sformatf("r_rdata_o[%0d]", m), exp[m], r_rdata[m]);
        end
    endtask

    // All cores on one bank with one winner per cycle in round-robin order
    task automatic test_conflict();
        logic [N_MASTER-1:0]   pending;
        logic [DATA_WIDTH-1:0] exp;
        int                    win;
        int                    prev;
        // Preload from core 3 down so the arbiter pointer rests on core 1
        for (int m = N_MASTER - 1; m >= 0; m--)
            do_access(m, 1'b1, ADDR_WIDTH'(16'h0300 + 4 * m + CONFLICT_BANK), $random(seed));
        @(negedge clk);
        for (int m = 0; m < N_MASTER; m++)
        begin
            req[m]            = 1'b1;
            core_req[m].wen   = 1'b0;
            core_req[m].addr  = ADDR_WIDTH'(16'h0300 + 4 * m + CONFLICT_BANK);
            core_req[m].wdata = '0;
        end
        pending = '1;
        prev    = -1;
        for (int cyc = 0; cyc <= N_MASTER; cyc++)
        begin
            #(SAMPLE_DLY);
            if (prev >= 0)
            begin
                check_val("r_valid_o", 1 << prev, r_valid);
                check_val($sformatf("r_rdata_o[%0d]", prev), exp, r_rdata[prev]);
            end
            if (pending != '0)
            begin
                win = rr_winner(pending, rr_ptr[CONFLICT_BANK]);
                check_val("gnt_o", 1 << win, gnt);
                model_grant(win, core_req[win], exp);
                pending[win] = 1'b0;
                prev         = win;
            end
            else
                check_val("gnt_o", 0, gnt);
            @(negedge clk);
            req = pending;
        end
    endtask

    // Random reads and writes from all cores held until granted
    task automatic test_random();
        logic [N_MASTER-1:0]   active;
        logic [N_MASTER-1:0]   due;
        logic [DATA_WIDTH-1:0] exp    [N_MASTER];
        int                    waited [N_MASTER];
        int                    issued;
        int                    done;
        int                    cycles;
        logic [31:0]           rnd;
        active = '0;
        due    = '0;
        issued = 0;
        done   = 0;
        cycles = 0;
        while (done < N_RANDOM || due != '0)
        begin
            cycles++;
            if (cycles > N_RANDOM * TIMEOUT)
                fail_stop("Random traffic did not complete within its cycle budget");
            @(negedge clk);
            for (int m = 0; m < N_MASTER; m++)
            begin
                rnd = $random(seed);
                if (!active[m] && issued < N_RANDOM && rnd[0])
                begin
                    active[m]         = 1'b1;
                    waited[m]         = 0;
                    issued++;
                    core_req[m].addr  = rnd[31:16];
                    // Reads go only to words that hold data
                    core_req[m].wen   = rnd[1] || !written[int'(rnd[25:16])];
                    core_req[m].wdata = $random(seed);
                end
                req[m] = active[m];
            end
            #(SAMPLE_DLY);
            for (int m = 0; m < N_MASTER; m++)
            begin
                check_val($sformatf("r_valid_o[%0d]", m), due[m], r_valid[m]);
                if (due[m])
                    check_val($sformatf("r_rdata_o[%0d]", m), exp[m], r_rdata[m]);
                due[m] = gnt[m];
                if (gnt[m])
                begin
                    model_grant(m, core_req[m], exp[m]);
                    active[m] = 1'b0;
                    done++;
                end
                else if (active[m])
                begin
                    waited[m]++;
                    if (waited[m] >= TIMEOUT)
                        fail_stop($sformatf("Core %0d waited too long for a grant", m));
                end
            end
        end
        @(negedge clk);
        req = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        seed     = 32'h6f54_1921;
        arst_n_i = 1'b0;
        req      = '0;
        core_req = '0;
        for (int b = 0; b < N_BANK; b++)
            rr_ptr[b] = 0;
        for (int w = 0; w < MEM_WORDS; w++)
            written[w] = 1'b0;
        repeat (16) @(negedge clk);
        arst_n_i = 1'b1;
        test_single_core();
        test_cross_core();
        test_parallel();
        test_conflict();
        test_random();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tests/log_interconnect_chk.sv */
/*
 * Interconnect protocol checker
 * Bound to the top level, watches grants and responses at the core ports
 */

`timescale 1ns/1ps

module log_interconnect_chk
#(
    parameter int N_MASTER = 4
)
(
    input logic                clk,
    input logic                arst_n_i,
    input logic [N_MASTER-1:0] req_i,
    input logic [N_MASTER-1:0] gnt_o,
    input logic [N_MASTER-1:0] r_valid_o
);

    // Grant goes only to a requesting core
    gnt_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (gnt_o & ~req_i) == '0)
        else $error("gnt_o high for a core without req_i");

    // Response one cycle after each grant, at no other time
    rvalid_after_gnt: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        r_valid_o == $past(gnt_o & req_i))
        else $error("r_valid_o does not follow the grants of the previous cycle");

    // Response lines quiet while reset is held
    rvalid_low_in_reset: assert property (
        @(posedge clk) !arst_n_i |-> r_valid_o == '0)
        else $error("r_valid_o high during reset");

endmodule

bind log_interconnect_top log_interconnect_chk #(
    .N_MASTER  (N_MASTER)
) log_interconnect_chk_i (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .req_i     (req_i),
    .gnt_o     (gnt_o),
    .r_valid_o (r_valid_o)
);

/* hw/log_interconnect_top.sv */
/*
 * Logarithmic interconnect top level
 * Joins N_MASTER cores to N_BANK word-interleaved banks through
 * per-core decoders, per-bank round-robin arbiters and a response router
 */

`timescale 1ns/1ps

module log_interconnect_top
#(
    parameter int N_MASTER = 4,
    parameter int N_BANK   = 4
)
(
    input  logic                                          clk,
    input  logic                                          arst_n_i,
    // Core request side
    input  logic [N_MASTER-1:0]                           req_i,
    input  tcdm_pkg::core_req_t [N_MASTER-1:0]            core_req_i,
    output logic [N_MASTER-1:0]                           gnt_o,
    // Core response side
    output logic [N_MASTER-1:0]                           r_valid_o,
    output logic [N_MASTER-1:0][tcdm_pkg::DATA_WIDTH-1:0] r_rdata_o
);

    import tcdm_pkg::*;

    localparam int ROUT_WIDTH = (N_BANK > 1) ? $clog2(N_BANK) : 1;

    // Row per core, column per bank
    logic [N_MASTER-1:0][N_BANK-1:0] req_row;
    logic [N_MASTER-1:0][N_BANK-1:0] gnt_row;
    logic [N_BANK-1:0][N_MASTER-1:0] req_col;
    logic [N_BANK-1:0][N_MASTER-1:0] gnt_col;

    logic [N_BANK-1:0]               bank_valid;
    bank_req_t [N_BANK-1:0]          bank_req;
    logic [N_BANK-1:0]               resp_valid;
    bank_resp_t [N_BANK-1:0]         resp;

    ////////////////////////////////////////////////////////////////////////////
    // Request decoders and matrix transposition
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_core
        addr_dec_req #(
            .N_BANK     (N_BANK),
            .ROUT_WIDTH (ROUT_WIDTH)
        ) addr_dec_req_i (
            .req_i      (req_i[m]),
            // Low address bits pick the bank
            .bank_sel_i (core_req_i[m].addr[ROUT_WIDTH-1:0]),
            .gnt_o      (gnt_o[m]),
            .bank_gnt_i (gnt_row[m]),
            .bank_req_o (req_row[m])
        );

        for (genvar b = 0; b < N_BANK; b++)
        begin : g_xpose
            assign req_col[b][m] = req_row[m][b];
            assign gnt_row[m][b] = gnt_col[b][m];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Arbiters and banks
    ////////////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < N_BANK; b++)
    begin : g_bank
        bank_arbiter #(
            .N_MASTER     (N_MASTER),
            .N_BANK       (N_BANK)
        ) bank_arbiter_i (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .req_i        (req_col[b]),
            .core_req_i   (core_req_i),
            .gnt_o        (gnt_col[b]),
            .bank_valid_o (bank_valid[b]),
            .bank_req_o   (bank_req[b])
        );

        mem_bank mem_bank_i (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .bank_valid_i (bank_valid[b]),
            .bank_req_i   (bank_req[b]),
            .resp_valid_o (resp_valid[b]),
            .resp_o       (resp[b])
        );
    end

    // Responses back to their owners
    resp_router #(
        .N_MASTER     (N_MASTER),
        .N_BANK       (N_BANK)
    ) resp_router_i (
        .resp_valid_i (resp_valid),
        .resp_i       (resp),
        .r_valid_o    (r_valid_o),
        .r_rdata_o    (r_rdata_o)
    );

endmodule

/* hw/resp_router.sv */
/*
 * Response router
 * Sends each bank response to the core named by its id,
 * at most one bank answers a given core per cycle
 */

`timescale 1ns/1ps

module resp_router
#(
    parameter int N_MASTER = 4,
    parameter int N_BANK   = 4
)
(
    // Bank side
    input  logic [N_BANK-1:0]                                resp_valid_i,
    input  tcdm_pkg::bank_resp_t [N_BANK-1:0]                resp_i,
    // Core side
    output logic [N_MASTER-1:0]                              r_valid_o,
    output logic [N_MASTER-1:0][tcdm_pkg::DATA_WIDTH-1:0]    r_rdata_o
);

    import tcdm_pkg::*;

    always_comb
    begin : route
        logic hit;
        r_valid_o = '0;
        r_rdata_o = '0;
        for (int m = 0; m < N_MASTER; m++)
        begin
            for (int b = 0; b < N_BANK; b++)
            begin
                // Valid answer tagged for core m
                hit = resp_valid_i[b] && (resp_i[b].id == MST_ID_WIDTH'(m));
                r_valid_o[m] = r_valid_o[m] | hit;
                // AND-OR select, single hit per core
                r_rdata_o[m] = r_rdata_o[m] | ({DATA_WIDTH{hit}} & resp_i[b].rdata);
            end
        end
    end

endmodule

/* hw/mem_bank.sv */
/*
 * Single-port memory bank with one cycle of latency
 * Writes on a valid write and returns the read or updated word,
 * tagged with the requesting core id, on the next cycle
 */

`timescale 1ns/1ps

module mem_bank
#(
    parameter int BANK_DEPTH = 256
)
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    // Request from the arbiter
    input  logic                 bank_valid_i,
    input  tcdm_pkg::bank_req_t  bank_req_i,
    // Tagged response, one cycle later
    output logic                 resp_valid_o,
    output tcdm_pkg::bank_resp_t resp_o
);

    import tcdm_pkg::*;

    localparam int BANK_AW = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    logic [DATA_WIDTH-1:0] mem_q [BANK_DEPTH];
    logic [BANK_AW-1:0]    word_idx;

    // Local word index within the bank
    assign word_idx = bank_req_i.addr[BANK_AW-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Storage and response data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (bank_valid_i)
        begin
            if (bank_req_i.wen)
            begin
                mem_q[word_idx] <= bank_req_i.wdata;
                // Write answers with the new value
                resp_o.rdata    <= bank_req_i.wdata;
            end
            else
                resp_o.rdata    <= mem_q[word_idx];
            // Keep the owner for the router
            resp_o.id <= bank_req_i.id;
        end
    end

    // Response strobe
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            resp_valid_o <= 1'b0;
        else
            resp_valid_o <= bank_valid_i;
    end

endmodule

/* hw/bank_arbiter.sv */
/*
 * Round-robin arbiter in front of one memory bank
 * Picks the first requesting core at or after the priority pointer,
 * grants it and forwards its payload with the bank-local address and id
 */

`timescale 1ns/1ps

module bank_arbiter
#(
    parameter int N_MASTER = 4,
    parameter int N_BANK   = 4
)
(
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    // Request column for this bank and all core payloads
    input  logic [N_MASTER-1:0]                  req_i,
    input  tcdm_pkg::core_req_t [N_MASTER-1:0]   core_req_i,
    // Grant column back to the decoders
    output logic [N_MASTER-1:0]                  gnt_o,
    // Winning request toward the bank
    output logic                                 bank_valid_o,
    output tcdm_pkg::bank_req_t                  bank_req_o
);

    import tcdm_pkg::*;

    localparam int ROUT_WIDTH = (N_BANK > 1) ? $clog2(N_BANK) : 1;
    // Bank select bits to drop, none with a single bank
    localparam int SEL_SHIFT  = (N_BANK > 1) ? ROUT_WIDTH : 0;
    localparam int PTR_WIDTH  = (N_MASTER > 1) ? $clog2(N_MASTER) : 1;

    logic [PTR_WIDTH-1:0] ptr_q;
    logic [PTR_WIDTH-1:0] ptr_next;
    logic [PTR_WIDTH-1:0] win_idx;
    logic                 win_found;
    core_req_t            win_req;

    ////////////////////////////////////////////////////////////////////////////
    // Winner selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin : rr_pick
        int unsigned idx;
        win_found = 1'b0;
        win_idx   = '0;
        // Scan starting at the pointer and wrap around
        for (int unsigned i = 0; i < N_MASTER; i++)
        begin
            idx = (ptr_q + i) % N_MASTER;
            if (!win_found && req_i[idx])
            begin
                win_found = 1'b1;
                win_idx   = PTR_WIDTH'(idx);
            end
        end
    end

    // One-hot grant, empty when nobody asks
    always_comb
    begin : gnt_dec
        gnt_o          = '0;
        gnt_o[win_idx] = win_found;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request toward the bank
    ////////////////////////////////////////////////////////////////////////////

    assign win_req      = core_req_i[win_idx];
    assign bank_valid_o = win_found;

    always_comb
    begin : bank_req_build
        bank_req_o.wen   = win_req.wen;
        // Strip the bank select bits
        bank_req_o.addr  = win_req.addr >> SEL_SHIFT;
        bank_req_o.wdata = win_req.wdata;
        // Winner index doubles as the response tag
        bank_req_o.id    = MST_ID_WIDTH'(win_idx);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Priority pointer
    ////////////////////////////////////////////////////////////////////////////

    // Core after the winner gets top priority next
    assign ptr_next = (int'(win_idx) == N_MASTER - 1) ? '0 : win_idx + 1'b1;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            ptr_q <= '0;
        else if (win_found)
            ptr_q <= ptr_next;
    end

endmodule

/* hw/addr_dec_req.sv */
/*
 * Request address decoder, one per core
 * Raises the request line of the bank picked by the routing bits and
 * routes the grant of that bank back to the core
 */

`timescale 1ns/1ps

module addr_dec_req
#(
    parameter int N_BANK     = 4,
    parameter int ROUT_WIDTH = (N_BANK > 1) ? $clog2(N_BANK) : 1
)
(
    // Core side
    input  logic                  req_i,
    input  logic [ROUT_WIDTH-1:0] bank_sel_i,
    output logic                  gnt_o,
    // Arbiter side, one line per bank
    input  logic [N_BANK-1:0]     bank_gnt_i,
    output logic [N_BANK-1:0]     bank_req_o
);

    generate
        if (N_BANK == 1)
        begin : g_single_bank
            // Only one target, nothing to decode
            assign bank_req_o[0] = req_i;
            assign gnt_o         = bank_gnt_i[0];
        end
        else
        begin : g_multi_bank
            always_comb
            begin : dec_req
                // All other banks stay quiet
                bank_req_o             = '0;
                // One-hot request toward the selected bank
                bank_req_o[bank_sel_i] = req_i;
                // Grant comes back from the same bank only
                gnt_o                  = bank_gnt_i[bank_sel_i];
            end
        end
    endgenerate

endmodule

/* hw/tcdm_pkg.sv */
/*
 * TCDM interconnect package
 * Word, address and core identifier widths, plus the request and response
 * structs that the decoders, arbiters, banks and response router share
 */

package tcdm_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Data word width
    localparam int DATA_WIDTH   = 32;
    // Core word address, bank select bits sit at the bottom
    localparam int ADDR_WIDTH   = 16;
    // Binary core identifier, up to 16 cores
    localparam int MST_ID_WIDTH = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Request and response payloads
    ////////////////////////////////////////////////////////////////////////////

    // Request as issued by a core
    typedef struct packed {
        logic                    wen;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
    } core_req_t;

    // Request as seen by a bank, local address and owner id attached
    typedef struct packed {
        logic                    wen;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
        logic [MST_ID_WIDTH-1:0] id;
    } bank_req_t;

    // Bank answer, id routes it back to the asking core
    typedef struct packed {
        logic [DATA_WIDTH-1:0]   rdata;
        logic [MST_ID_WIDTH-1:0] id;
    } bank_resp_t;

endpackage
